// File: build.f
verilog/calc_pkg.sv
verilog/keypad_scanner.sv
verilog/calc_core.sv
verilog/calc_top.sv
bench/keypad_model.sv
bench/calc_props.sv
bench/calc_tb.sv

// File: bench/calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    localparam int SETTLE    = 2;
    localparam int DEBOUNCE  = 20;
    localparam int SCAN_CYC  = 4 * SETTLE;
    localparam int IDLE_CYC  = 5 * SCAN_CYC;          // released time between keys
    localparam int EVENT_TMO = 20 * SCAN_CYC + 2 * DEBOUNCE;

    localparam logic [3:0] K_ADD   = 4'd3;
    localparam logic [3:0] K_SUB   = 4'd7;
    localparam logic [3:0] K_MUL   = 4'd11;
    localparam logic [3:0] K_NEG   = 4'd12;
    localparam logic [3:0] K_ZERO  = 4'd13;
    localparam logic [3:0] K_EQUAL = 4'd14;
    localparam logic [3:0] K_CLEAR = 4'd15;

    logic               clk;
    logic               nRST;
    logic [3:0]         row;
    logic [3:0]         col;
    logic signed [15:0] display_value;
    logic               result_valid;
    logic               entry_neg;
    logic               pressed;
    logic [3:0]         pressed_key;

    integer seed = 32'h4f2c549e;
    string  cur_test;
    int     test_err;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     key_events = 0;
    int     rv_pulses = 0;

    // reference calculator state
    int     exp_entry;
    bit     exp_sign;
    int     exp_cnt;
    int     exp_acc;
    op_t    exp_op;
    bit     exp_show;
    int     exp_disp;

    calc_top #(
        .DATA_W          (16),
        .MAX_DIGITS      (4),
        .DEBOUNCE_CYCLES (DEBOUNCE),
        .SETTLE_CYCLES   (SETTLE)
    ) u_dut (
        .clk           (clk),
        .nRST          (nRST),
        .row           (row),
        .col           (col),
        .display_value (display_value),
        .result_valid  (result_valid),
        .entry_neg     (entry_neg)
    );

    keypad_model u_keypad (
        .col         (col),
        .pressed     (pressed),
        .pressed_key (pressed_key),
        .row         (row)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // strobes and pulses counted as the flops hold them
    always @(posedge clk) begin
        if (u_dut.digit_strobe || u_dut.op_strobe || u_dut.neg_strobe ||
            u_dut.equal_strobe || u_dut.clear_strobe)
            key_events <= key_events + 1;
        if (result_valid)
            rv_pulses <= rv_pulses + 1;
    end

    function automatic int wrap_to_16(input int v);
        logic signed [15:0] t;
        t = v[15:0];
        return int'(t);
    endfunction

    function automatic int expected_result(input int lhs, input int rhs, input op_t op);
        int r;
        case (op)
            OP_ADD:  r = lhs + rhs;
            OP_SUB:  r = lhs - rhs;
            OP_MUL:  r = lhs * rhs;
            default: r = rhs;
        endcase
        return wrap_to_16(r);
    endfunction

    function automatic logic [3:0] key_of_digit(input int d);
        if (d == 0)
            return K_ZERO;
        return 4'(((d - 1) / 3) * 4 + (d - 1) % 3);   // 1..9 on rows 0..2
    endfunction

    function automatic void check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAILED %s (%s): expected %0d, actual %0d", cur_test, what, expected, actual);
            test_err++;
        end
    endfunction

    function automatic void clear_model();
        exp_entry = 0;
        exp_sign  = 1'b0;
        exp_cnt   = 0;
        exp_acc   = 0;
        exp_op    = OP_NONE;
        exp_show  = 1'b0;
        exp_disp  = 0;
    endfunction

    function automatic void apply_key_to_model(input logic [3:0] key);
        int d;
        int signed_entry;
        int lhs;
        d = -1;
        for (int k = 0; k < 10; k++) begin
            if (key_of_digit(k) == key)
                d = k;
        end
        signed_entry = exp_sign ? -exp_entry : exp_entry;
        if (key == K_CLEAR) begin
            clear_model();
        end else if (d >= 0) begin
            if (exp_show) begin                     // fresh entry after a result
                exp_entry = d;
                exp_sign  = 1'b0;
                exp_cnt   = 1;
                exp_show  = 1'b0;
                exp_disp  = d;
            end else if (exp_cnt < 4) begin
                exp_entry = exp_entry * 10 + d;
                exp_cnt++;
                exp_disp  = wrap_to_16(exp_sign ? -exp_entry : exp_entry);
            end
        end else if (key == K_NEG) begin
            exp_sign = !exp_sign;
            exp_show = 1'b0;
            exp_disp = wrap_to_16(exp_sign ? -exp_entry : exp_entry);
        end else if (key == K_EQUAL) begin
            exp_acc   = expected_result(exp_acc, signed_entry, exp_op);
            exp_op    = OP_NONE;
            exp_entry = 0;
            exp_sign  = 1'b0;
            exp_cnt   = 0;
            exp_show  = 1'b1;
            exp_disp  = exp_acc;
        end else begin
            if (exp_op == OP_NONE || exp_show)
                lhs = exp_disp;
            else
                lhs = expected_result(exp_acc, signed_entry, exp_op);
            exp_acc   = lhs;
            exp_op    = (key == K_ADD) ? OP_ADD : (key == K_SUB) ? OP_SUB : OP_MUL;
            exp_entry = 0;
            exp_sign  = 1'b0;
            exp_cnt   = 0;
            exp_show  = 1'b0;
            exp_disp  = lhs;
        end
    endfunction

    // press, optionally bounce first, hold, release, then check
    task automatic press_key(input logic [3:0] key, input int extra_hold, input bit bounce);
        int ev0;
        int rv0;
        int n;
        int gap;
        ev0 = key_events;
        rv0 = rv_pulses;
        if (bounce) begin
            for (int i = 0; i < 8; i++) begin
                @(posedge clk);
                pressed_key <= key;
                pressed     <= ~pressed;
                gap = $unsigned($random(seed)) % 2;
                repeat (gap) @(posedge clk);
            end
        end
        @(posedge clk);
        pressed_key <= key;
        pressed     <= 1'b1;
        n = 0;
        while (key_events == ev0 && n < EVENT_TMO) begin
            @(negedge clk);
            n++;
        end
        if (key_events == ev0) begin
            $display("timeout in %s: key %0d was held but no key event came", cur_test, key);
            test_err++;
        end
        repeat (extra_hold) @(posedge clk);
        @(posedge clk);
        pressed <= 1'b0;
        repeat (IDLE_CYC) @(posedge clk);
        @(negedge clk);
        apply_key_to_model(key);
        check_value("display", exp_disp, display_value);
        check_value("key events", 1, key_events - ev0);
        check_value("result pulses", (key == K_EQUAL) ? 1 : 0, rv_pulses - rv0);
        check_value("entry_neg", exp_sign ? 1 : 0, int'(entry_neg));
    endtask

    task automatic enter_number(input int value);
        int q[$];
        int v;
        v = value;
        if (v == 0)
            q.push_back(0);
        while (v > 0) begin
            q.push_front(v % 10);
            v = v / 10;
        end
        foreach (q[i])
            press_key(key_of_digit(q[i]), 0, 1'b0);
    endtask

    function automatic logic [3:0] random_op_key();
        case ($unsigned($random(seed)) % 3)
            0:       return K_ADD;
            1:       return K_SUB;
            default: return K_MUL;
        endcase
    endfunction

    task automatic begin_test(input string name);
        cur_test = name;
        test_err = 0;
        press_key(K_CLEAR, 0, 1'b0);
    endtask

    task automatic end_test();
        if (test_err == 0) begin
            $display("test %s: passed", cur_test);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", cur_test, test_err);
            tests_failed++;
        end
    endtask

    initial begin
        nRST        = 1'b0;
        pressed     = 1'b0;
        pressed_key = 4'd0;
        clear_model();
        repeat (2) @(posedge clk);
        nRST <= 1'b1;
        repeat (4) @(posedge clk);

        begin_test("digit_entry");
        enter_number(1234);
        press_key(key_of_digit(5), 0, 1'b0);   // fifth digit is ignored
        press_key(K_CLEAR, 0, 1'b0);
        enter_number(70);                      // key 13 as zero
        end_test();

        begin_test("arithmetic");
        for (int i = 0; i < 6; i++) begin
            press_key(K_CLEAR, 0, 1'b0);
            enter_number($unsigned($random(seed)) % 10000);
            press_key(random_op_key(), 0, 1'b0);
            enter_number($unsigned($random(seed)) % 10000);
            press_key(K_EQUAL, 0, 1'b0);
        end
        end_test();

        begin_test("chaining_sign");
        for (int i = 0; i < 2; i++) begin
            press_key(K_CLEAR, 0, 1'b0);
            enter_number($unsigned($random(seed)) % 1000);
            press_key(random_op_key(), 0, 1'b0);
            enter_number($unsigned($random(seed)) % 1000);
            press_key(K_NEG, 0, 1'b0);         // entry goes negative
            press_key(random_op_key(), 0, 1'b0);
            enter_number($unsigned($random(seed)) % 100);
            press_key(K_EQUAL, 0, 1'b0);
        end
        end_test();

        begin_test("debounce");
        press_key(key_of_digit(5), 0, 1'b1);
        press_key(key_of_digit(6), 10 * DEBOUNCE, 1'b0);
        end_test();

        begin_test("clear_reuse");
        enter_number(12);
        press_key(K_ADD, 0, 1'b0);
        enter_number(3);
        press_key(K_EQUAL, 0, 1'b0);
        press_key(K_MUL, 0, 1'b0);             // result as left operand
        enter_number(4);
        press_key(K_EQUAL, 0, 1'b0);
        enter_number(2);                       // fresh entry after result
        press_key(K_CLEAR, 0, 1'b0);
        end_test();

        if (u_dut.u_props.fail_count != 0)
            $display("concurrent assertions failed %0d times", u_dut.u_props.fail_count);
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && u_dut.u_props.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/calc_props.sv
`timescale 1ns/1ps
`default_nettype none

module calc_props (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row,
    input  logic [3:0] col,
    input  logic       digit_strobe,
    input  logic       op_strobe,
    input  logic       neg_strobe,
    input  logic       equal_strobe,
    input  logic       clear_strobe,
    input  logic       result_valid
);

    int         fail_count = 0;
    logic [3:0] col_empty;     // last look at each column showed no key
    logic       released;      // a whole keyless scan since the last strobe
    logic       any_strobe;

    assign any_strobe = digit_strobe | op_strobe | neg_strobe | equal_strobe | clear_strobe;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            col_empty <= 4'hF;
            released  <= 1'b1;
        end else if (any_strobe) begin
            col_empty <= 4'h0;
            released  <= 1'b0;
        end else begin
            for (int c = 0; c < 4; c++) begin
                if (!col[c])
                    col_empty[c] <= (row == 4'hF);
            end
            if (&col_empty)
                released <= 1'b1;
        end
    end

    col_one_low: assert property (@(posedge clk) disable iff (!nRST)
        $past(nRST) |-> $onehot(~col))
        else begin
            $error("col does not have exactly one low bit");
            fail_count++;
        end

    strobes_onehot: assert property (@(posedge clk) disable iff (!nRST)
        $onehot0({digit_strobe, op_strobe, neg_strobe, equal_strobe, clear_strobe}))
        else begin
            $error("more than one scanner strobe in a cycle");
            fail_count++;
        end

    valid_after_equal: assert property (@(posedge clk) disable iff (!nRST)
        equal_strobe |=> result_valid)
        else begin
            $error("result_valid missing one cycle after equal_strobe");
            fail_count++;
        end

    valid_only_after_equal: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |-> $past(equal_strobe))
        else begin
            $error("result_valid without equal_strobe in the cycle before");
            fail_count++;
        end

    strobe_needs_release: assert property (@(posedge clk) disable iff (!nRST)
        any_strobe |-> released)
        else begin
            $error("second strobe before a scan with no key");
            fail_count++;
        end

endmodule

bind calc_top calc_props u_props (
    .clk          (clk),
    .nRST         (nRST),
    .row          (row),
    .col          (col),
    .digit_strobe (digit_strobe),
    .op_strobe    (op_strobe),
    .neg_strobe   (neg_strobe),
    .equal_strobe (equal_strobe),
    .clear_strobe (clear_strobe),
    .result_valid (result_valid)
);

`default_nettype wire

// File: bench/keypad_model.sv
`timescale 1ns/1ps
`default_nettype none

// 4x4 matrix keypad, one key at a time
module keypad_model (
    input  logic [3:0] col,          // active low column drive
    input  logic       pressed,
    input  logic [3:0] pressed_key,  // row*4 + column
    output logic [3:0] row           // active low, idle high
);

    logic [1:0] key_row;
    logic [1:0] key_col;

    assign key_row = pressed_key[3:2];
    assign key_col = pressed_key[1:0];

    // a closed switch connects its row to its column
    always_comb begin
        row = 4'hF;
        if (pressed && (col[key_col] == 1'b0))
            row[key_row] = 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top #(
    parameter int DATA_W          = calc_pkg::DATA_W_DEF,
    parameter int MAX_DIGITS      = calc_pkg::MAX_DIGITS_DEF,
    parameter int DEBOUNCE_CYCLES = calc_pkg::DEBOUNCE_DEF,
    parameter int SETTLE_CYCLES   = calc_pkg::SETTLE_DEF
) (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic [3:0]               row,
    output logic [3:0]               col,
    output logic signed [DATA_W-1:0] display_value,
    output logic                     result_valid,
    output logic                     entry_neg
);
    import calc_pkg::*;

    logic               digit_strobe;
    logic [DIGIT_W-1:0] digit_value;
    logic               op_strobe;
    op_t                op_code;
    logic               neg_strobe;
    logic               equal_strobe;
    logic               clear_strobe;

    keypad_scanner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .SETTLE_CYCLES   (SETTLE_CYCLES)
    ) u_scanner (
        .clk          (clk),
        .nRST         (nRST),
        .row          (row),
        .col          (col),
        .digit_strobe (digit_strobe),
        .digit_value  (digit_value),
        .op_strobe    (op_strobe),
        .op_code      (op_code),
        .neg_strobe   (neg_strobe),
        .equal_strobe (equal_strobe),
        .clear_strobe (clear_strobe)
    );

    calc_core #(
        .DATA_W     (DATA_W),
        .MAX_DIGITS (MAX_DIGITS)
    ) u_core (
        .clk           (clk),
        .nRST          (nRST),
        .digit_strobe  (digit_strobe),
        .digit_value   (digit_value),
        .op_strobe     (op_strobe),
        .op_code       (op_code),
        .neg_strobe    (neg_strobe),
        .equal_strobe  (equal_strobe),
        .clear_strobe  (clear_strobe),
        .display_value (display_value),
        .result_valid  (result_valid),
        .entry_neg     (entry_neg)
    );

endmodule

`default_nettype wire

// File: verilog/calc_core.sv
`timescale 1ns/1ps
`default_nettype none

module calc_core #(
    parameter int DATA_W     = calc_pkg::DATA_W_DEF,
    parameter int MAX_DIGITS = calc_pkg::MAX_DIGITS_DEF
) (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic                           digit_strobe,
    input  logic [calc_pkg::DIGIT_W-1:0]   digit_value,
    input  logic                           op_strobe,
    input  calc_pkg::op_t                  op_code,
    input  logic                           neg_strobe,
    input  logic                           equal_strobe,
    input  logic                           clear_strobe,
    output logic signed [DATA_W-1:0]       display_value,
    output logic                           result_valid,
    output logic                           entry_neg
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(MAX_DIGITS + 1);

    logic [DATA_W-1:0]        entry_mag;       // magnitude of the typed number
    logic [DATA_W-1:0]        entry_mag_nxt;
    logic                     entry_sign;
    logic [CNT_W-1:0]         digit_cnt;
    logic signed [DATA_W-1:0] entry_val;
    logic signed [DATA_W-1:0] acc;
    logic signed [DATA_W-1:0] eval_val;
    logic signed [DATA_W-1:0] op_lhs;
    op_t                      pend_op;
    logic                     show_result;     // display holds a result

    // everything wraps to DATA_W bits
    function automatic logic signed [DATA_W-1:0] apply_op(
        input logic signed [DATA_W-1:0] lhs,
        input logic signed [DATA_W-1:0] rhs,
        input op_t                      op
    );
        case (op)
            OP_ADD:  apply_op = lhs + rhs;
            OP_SUB:  apply_op = lhs - rhs;
            OP_MUL:  apply_op = lhs * rhs;
            default: apply_op = rhs;          // nothing pending
        endcase
    endfunction

    function automatic logic signed [DATA_W-1:0] signed_entry(
        input logic [DATA_W-1:0] mag,
        input logic              neg
    );
        signed_entry = neg ? -$signed(mag) : $signed(mag);
    endfunction

    assign entry_mag_nxt = entry_mag * DATA_W'(10) + DATA_W'(digit_value);
    assign entry_val     = signed_entry(entry_mag, entry_sign);
    assign eval_val      = apply_op(acc, entry_val, pend_op);
    assign entry_neg     = entry_sign;

    // left operand for a new operator
    assign op_lhs = ((pend_op == OP_NONE) || show_result) ? display_value : eval_val;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry_mag     <= '0;
            entry_sign    <= 1'b0;
            digit_cnt     <= '0;
            acc           <= '0;
            pend_op       <= OP_NONE;
            show_result   <= 1'b0;
            display_value <= '0;
            result_valid  <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (clear_strobe) begin
                entry_mag     <= '0;
                entry_sign    <= 1'b0;
                digit_cnt     <= '0;
                acc           <= '0;
                pend_op       <= OP_NONE;
                show_result   <= 1'b0;
                display_value <= '0;
            end else if (digit_strobe) begin
                if (show_result) begin
                    // fresh entry after a result
                    entry_mag     <= DATA_W'(digit_value);
                    entry_sign    <= 1'b0;
                    digit_cnt     <= CNT_W'(1);
                    show_result   <= 1'b0;
                    display_value <= signed_entry(DATA_W'(digit_value), 1'b0);
                end else if (digit_cnt < CNT_W'(MAX_DIGITS)) begin
                    entry_mag     <= entry_mag_nxt;
                    digit_cnt     <= digit_cnt + 1'b1;
                    display_value <= signed_entry(entry_mag_nxt, entry_sign);
                end
            end else if (neg_strobe) begin
                entry_sign    <= ~entry_sign;
                show_result   <= 1'b0;
                display_value <= signed_entry(entry_mag, ~entry_sign);
            end else if (op_strobe) begin
                acc           <= op_lhs;
                pend_op       <= op_code;
                entry_mag     <= '0;
                entry_sign    <= 1'b0;
                digit_cnt     <= '0;
                show_result   <= 1'b0;
                display_value <= op_lhs;
            end else if (equal_strobe) begin
                acc           <= eval_val;
                pend_op       <= OP_NONE;
                entry_mag     <= '0;
                entry_sign    <= 1'b0;
                digit_cnt     <= '0;
                show_result   <= 1'b1;
                display_value <= eval_val;
                result_valid  <= 1'b1;    // same cycle as the new value
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner #(
    parameter int DEBOUNCE_CYCLES = calc_pkg::DEBOUNCE_DEF,
    parameter int SETTLE_CYCLES   = calc_pkg::SETTLE_DEF
) (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [3:0]                     row,           // active low
    output logic [3:0]                     col,           // active low, one at a time
    output logic                           digit_strobe,
    output logic [calc_pkg::DIGIT_W-1:0]   digit_value,
    output logic                           op_strobe,
    output calc_pkg::op_t                  op_code,
    output logic                           neg_strobe,
    output logic                           equal_strobe,
    output logic                           clear_strobe
);
    import calc_pkg::*;

    localparam int SET_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
    localparam int DB_W  = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic [1:0] {
        SCAN,
        DEBOUNCE,
        EMIT,
        RELEASE
    } state_t;

    state_t state;

    logic [3:0]         row_meta;
    logic [3:0]         row_sync;
    logic [1:0]         col_idx;
    logic [1:0]         col_idx_nxt;
    logic [SET_W-1:0]   settle_cnt;
    logic               col_last;
    logic [1:0]         samp_vld;      // col_last delayed to line up with row_sync
    logic [1:0]         idx_d1;
    logic [1:0]         idx_d2;
    logic [15:0]        key_acc;       // matrix being assembled
    logic [15:0]        key_matrix;    // key_acc merged with the current sample
    logic               scan_done;
    logic               single_key;
    logic [KEY_W-1:0]   scan_key;
    logic [KEY_W-1:0]   cand_key;
    logic [DB_W-1:0]    db_cnt;
    logic               db_done;

    logic               dec_digit;
    logic               dec_op;
    logic               dec_neg;
    logic               dec_equal;
    logic               dec_clear;
    logic [DIGIT_W-1:0] dec_value;
    op_t                dec_op_code;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_meta <= 4'hF;
            row_sync <= 4'hF;
        end else begin
            row_meta <= row;       // two-flop synchronizer
            row_sync <= row_meta;
        end
    end

    assign col_last    = (settle_cnt == SET_W'(SETTLE_CYCLES - 1));
    assign col_idx_nxt = col_last ? col_idx + 2'd1 : col_idx;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            settle_cnt <= '0;
            col_idx    <= 2'd0;
            col        <= 4'b1111;
        end else begin
            settle_cnt <= col_last ? '0 : settle_cnt + 1'b1;
            col_idx    <= col_idx_nxt;
            col        <= ~(4'b0001 << col_idx_nxt);
        end
    end

    // the rows seen in a column's last cycle reach row_sync two cycles later
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            samp_vld <= 2'b00;
            idx_d1   <= 2'd0;
            idx_d2   <= 2'd0;
            key_acc  <= 16'd0;
        end else begin
            samp_vld <= {samp_vld[0], col_last};
            idx_d1   <= col_idx;
            idx_d2   <= idx_d1;
            if (samp_vld[1])
                key_acc <= key_matrix;
        end
    end

    always_comb begin
        key_matrix = key_acc;
        for (int r = 0; r < 4; r++) begin
            key_matrix[r*4 + idx_d2] = ~row_sync[r];
        end
    end

    always_comb begin
        scan_key = '0;
        for (int i = 0; i < 16; i++) begin
            if (key_matrix[i])
                scan_key = KEY_W'(i);
        end
    end

    assign scan_done  = samp_vld[1] && (idx_d2 == 2'd3);  // last column of a scan
    assign single_key = (|key_matrix) && ((key_matrix & (key_matrix - 16'd1)) == 16'd0);
    assign db_done    = (db_cnt == DB_W'(DEBOUNCE_CYCLES));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= SCAN;
            cand_key <= '0;
            db_cnt   <= '0;
        end else begin
            case (state)
                SCAN: begin
                    if (scan_done && single_key) begin
                        cand_key <= scan_key;
                        db_cnt   <= '0;
                        state    <= DEBOUNCE;
                    end
                end
                DEBOUNCE: begin
                    if (!db_done)
                        db_cnt <= db_cnt + 1'b1;
                    if (scan_done) begin
                        if (!single_key) begin
                            state <= SCAN;            // released or several keys
                        end else if (scan_key != cand_key) begin
                            cand_key <= scan_key;     // other key, start over
                            db_cnt   <= '0;
                        end else if (db_done) begin
                            state <= EMIT;
                        end
                    end
                end
                EMIT: begin
                    state <= RELEASE;
                end
                RELEASE: begin
                    if (scan_done && (key_matrix == 16'd0))
                        state <= SCAN;
                end
                default: state <= SCAN;
            endcase
        end
    end

    always_comb begin
        dec_digit   = 1'b0;
        dec_op      = 1'b0;
        dec_neg     = 1'b0;
        dec_equal   = 1'b0;
        dec_clear   = 1'b0;
        dec_value   = '0;
        dec_op_code = OP_NONE;
        case (cand_key)
            KEY_ADD: begin
                dec_op      = 1'b1;
                dec_op_code = OP_ADD;
            end
            KEY_SUB: begin
                dec_op      = 1'b1;
                dec_op_code = OP_SUB;
            end
            KEY_MUL: begin
                dec_op      = 1'b1;
                dec_op_code = OP_MUL;
            end
            KEY_NEG:   dec_neg   = 1'b1;
            KEY_ZERO:  dec_digit = 1'b1;
            KEY_EQUAL: dec_equal = 1'b1;
            KEY_CLEAR: dec_clear = 1'b1;
            default: begin
                dec_digit = 1'b1;
                dec_value = {2'b00, cand_key[3:2]} * 4'd3 + {2'b00, cand_key[1:0]} + 4'd1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            digit_strobe <= 1'b0;
            op_strobe    <= 1'b0;
            neg_strobe   <= 1'b0;
            equal_strobe <= 1'b0;
            clear_strobe <= 1'b0;
        end else begin
            digit_strobe <= (state == EMIT) && dec_digit;
            op_strobe    <= (state == EMIT) && dec_op;
            neg_strobe   <= (state == EMIT) && dec_neg;
            equal_strobe <= (state == EMIT) && dec_equal;
            clear_strobe <= (state == EMIT) && dec_clear;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EMIT) begin
            digit_value <= dec_value;
            op_code     <= dec_op_code;
        end
    end

endmodule

`default_nettype wire

// File: verilog/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // operator codes
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,
        OP_SUB  = 2'b01,
        OP_MUL  = 2'b10,
        OP_NONE = 2'b11
    } op_t;

    // key index = row*4 + column
    localparam int KEY_W   = 4;
    localparam int DIGIT_W = 4;

    // defaults used by the top level
    localparam int DATA_W_DEF     = 16;
    localparam int MAX_DIGITS_DEF = 4;
    localparam int DEBOUNCE_DEF   = 1_000_000;  // clock cycles
    localparam int SETTLE_DEF     = 4;          // cycles per column

    // keys that are not plain digits
    // digits 1..9 sit on rows 0..2, columns 0..2
    localparam logic [KEY_W-1:0] KEY_ADD   = 4'd3;   // A
    localparam logic [KEY_W-1:0] KEY_SUB   = 4'd7;   // B
    localparam logic [KEY_W-1:0] KEY_MUL   = 4'd11;  // C
    localparam logic [KEY_W-1:0] KEY_NEG   = 4'd12;  // D
    localparam logic [KEY_W-1:0] KEY_ZERO  = 4'd13;
    localparam logic [KEY_W-1:0] KEY_EQUAL = 4'd14;  // '*'
    localparam logic [KEY_W-1:0] KEY_CLEAR = 4'd15;  // '#'

endpackage

`default_nettype wire
